/* build.f */
rtl/rpc_pkg.sv
rtl/rpc_reg_block.sv
rtl/rpc_cmd_queue.sv
rtl/rpc_bus_sequencer.sv
rtl/rpc_ctrl_top.sv
sim/hyperram_model.sv
sim/tb_rpc_ctrl.sv

/* rtl/rpc_bus_sequencer.sv */
`default_nettype none

module rpc_bus_sequencer (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 ctrl_enable,
   input  wire rpc_pkg::rpc_timing_t timing,
   input  wire logic                 head_valid,
   input  wire rpc_pkg::rpc_req_t    head,
   input  wire logic                 rwds_in,
   input  wire logic [7:0]           dq_in0,
   input  wire logic [7:0]           dq_in1,
   output logic                      pop,
   output logic                      busy,
   output logic                      csn,
   output logic                      ck_en,
   output logic                      dq_out_en,
   output logic      [7:0]           dq_out0,
   output logic      [7:0]           dq_out1,
   output logic                      wds_en,
   output logic                      wds0,
   output logic                      wds1,
   output logic                      rsp_valid,
   output rpc_pkg::rpc_data_t        rsp_data,
   output logic                      rsp_last
);

   import rpc_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_CA,
      ST_LAT,
      ST_DATA,
      ST_HOLD,
      ST_CSHI
   } seq_state_t;

   seq_state_t state;
   logic [3:0] cnt;                                    // Phase cycle counter
   logic [3:0] rd_cnt;                                 // Read words captured
   logic [3:0] cshi_load;
   rpc_req_t   req_q;
   rpc_ca_u    ca_build;
   rpc_ca_u    ca_q;
   logic       start_ok;
   logic       rd_beat;
   logic       rd_done;
   logic       in_txn;

   // --------------------------------------------------------------------------
   // Command-address word from the queue head
   // --------------------------------------------------------------------------
   always_comb begin
      ca_build.f = '{
         rw:           head.is_read,
         as:           1'b0,
         burst_linear: 1'b1,
         upper_addr:   head.addr[28:3],
         reserved:     16'd0,
         lower_addr:   head.addr[2:0]
      };
   end

   // Last CSHI cycle may overlap with the next pop
   assign start_ok  = (state == ST_IDLE) || ((state == ST_CSHI) && (cnt == 4'd0));
   assign pop       = start_ok && ctrl_enable && head_valid;
   assign rd_beat   = (state == ST_DATA) && req_q.is_read && rwds_in;
   assign rd_done   = rd_beat && (rd_cnt == req_q.len);
   assign cshi_load = (timing.cshi == 4'd0) ? 4'd0 : timing.cshi - 4'd1;

   // --------------------------------------------------------------------------
   // Phase FSM
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= ST_IDLE;
         cnt    <= 4'd0;
         rd_cnt <= 4'd0;
      end else begin
         case (state)
            ST_IDLE, ST_CSHI: begin
               if (pop) begin
                  rd_cnt <= 4'd0;
                  if (timing.css == 4'd0) begin
                     state <= ST_CA;
                     cnt   <= 4'(RPC_CA_CYCLES - 1);
                  end else begin
                     state <= ST_SETUP;
                     cnt   <= timing.css - 4'd1;
                  end
               end else if (state == ST_CSHI) begin
                  if (cnt == 4'd0) begin
                     state <= ST_IDLE;
                  end else begin
                     cnt <= cnt - 4'd1;
                  end
               end
            end
            ST_SETUP: begin
               if (cnt == 4'd0) begin
                  state <= ST_CA;
                  cnt   <= 4'(RPC_CA_CYCLES - 1);
               end else begin
                  cnt <= cnt - 4'd1;
               end
            end
            ST_CA: begin
               if (cnt != 4'd0) begin
                  cnt <= cnt - 4'd1;
               end else if (req_q.is_read || (timing.latency == 4'd0)) begin
                  state <= ST_DATA;                    // Reads wait on rwds_in
               end else begin
                  state <= ST_LAT;
                  cnt   <= timing.latency - 4'd1;
               end
            end
            ST_LAT: begin
               if (cnt == 4'd0) begin
                  state <= ST_DATA;
               end else begin
                  cnt <= cnt - 4'd1;
               end
            end
            ST_DATA: begin
               if (rd_beat) begin
                  rd_cnt <= rd_cnt + 4'd1;
               end
               if (!req_q.is_read || rd_done) begin
                  if (timing.csh == 4'd0) begin
                     state <= ST_CSHI;
                     cnt   <= cshi_load;
                  end else begin
                     state <= ST_HOLD;
                     cnt   <= timing.csh - 4'd1;
                  end
               end
            end
            ST_HOLD: begin
               if (cnt == 4'd0) begin
                  state <= ST_CSHI;
                  cnt   <= cshi_load;
               end else begin
                  cnt <= cnt - 4'd1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Request latch and CA shifter, two bytes out per clock
   always_ff @(posedge clk) begin
      if (pop) begin
         req_q <= head;
         ca_q  <= ca_build;
      end else if (state == ST_CA) begin
         ca_q.b <= {ca_q.b[3:0], 16'h0000};
      end
   end

   // --------------------------------------------------------------------------
   // Read capture
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
         rsp_last  <= 1'b0;
      end else begin
         rsp_valid <= rd_beat;
         rsp_last  <= rd_done;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_beat) begin
         rsp_data <= {dq_in0, dq_in1};                 // Rising half is high byte
      end
   end

   // --------------------------------------------------------------------------
   // Bus outputs
   // --------------------------------------------------------------------------
   assign in_txn    = (state != ST_IDLE) && (state != ST_CSHI);
   assign csn       = !in_txn;
   assign busy      = pop || in_txn;
   assign ck_en     = (state == ST_CA) || (state == ST_LAT) || (state == ST_DATA);
   assign wds_en    = (state == ST_DATA) && !req_q.is_read;
   assign dq_out_en = (state == ST_CA) || wds_en;
   assign dq_out0   = (state == ST_CA) ? ca_q.b[5] : req_q.wdata[15:8];
   assign dq_out1   = (state == ST_CA) ? ca_q.b[4] : req_q.wdata[7:0];
   assign wds0      = req_q.wmask[1];
   assign wds1      = req_q.wmask[0];

   a_ck_under_cs: assert property (@(posedge clk) disable iff (reset)
      ck_en |-> !csn)
      else $error("Error: ck_en active with csn high");

   a_no_drive_with_rsp: assert property (@(posedge clk) disable iff (reset)
      !(dq_out_en && rsp_valid))
      else $error("Error: dq_out_en and rsp_valid both high");

endmodule

`default_nettype wire

/* rtl/rpc_cmd_queue.sv */
`default_nettype none

module rpc_cmd_queue (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              req_valid,
   input  wire rpc_pkg::rpc_req_t req,
   input  wire logic              pop,
   output logic                   head_valid,
   output rpc_pkg::rpc_req_t      head,
   output logic                   credit
);

   import rpc_pkg::*;

   rpc_req_t                               mem [RPC_QUEUE_DEPTH];
   logic [$clog2(RPC_QUEUE_DEPTH)-1:0]     wr_ptr;
   logic [$clog2(RPC_QUEUE_DEPTH)-1:0]     rd_ptr;
   logic [$clog2(RPC_QUEUE_DEPTH+1)-1:0]   count;

   // Entry storage
   always_ff @(posedge clk) begin
      if (req_valid) begin
         mem[wr_ptr] <= req;
      end
   end

   // Depth is a power of two, so the pointers wrap on their own
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (req_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({req_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];
   assign credit     = pop;                            // One credit back per entry

   a_push_full: assert property (@(posedge clk) disable iff (reset)
      req_valid |-> (count != RPC_QUEUE_DEPTH))
      else $error("Error: request pushed while queue is full");

   a_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> head_valid)
      else $error("Error: pop while queue is empty");

endmodule

`default_nettype wire

/* rtl/rpc_ctrl_top.sv */
`default_nettype none

module rpc_ctrl_top (
   input  wire logic              clk,
   input  wire logic              reset,
   // Request and response channels
   input  wire logic              req_valid,
   input  wire rpc_pkg::rpc_req_t req,
   output logic                   credit,
   output logic                   rsp_valid,
   output rpc_pkg::rpc_data_t     rsp_data,
   output logic                   rsp_last,
   // Register port
   input  wire logic              reg_wr,
   input  wire logic              reg_rd,
   input  wire logic [1:0]        reg_addr,
   input  wire logic [31:0]       reg_wdata,
   output logic      [31:0]       reg_rdata,
   // Memory bus
   input  wire logic              rwds_in,
   input  wire logic [7:0]        dq_in0,
   input  wire logic [7:0]        dq_in1,
   output logic                   csn,
   output logic                   ck_en,
   output logic                   dq_out_en,
   output logic      [7:0]        dq_out0,
   output logic      [7:0]        dq_out1,
   output logic                   wds_en,
   output logic                   wds0,
   output logic                   wds1
);

   import rpc_pkg::*;

   logic        ctrl_enable;
   rpc_timing_t timing;
   logic        busy;
   logic        head_valid;
   rpc_req_t    head;
   logic        pop;

   // --------------------------------------------------------------------------
   // Configuration registers
   // --------------------------------------------------------------------------
   rpc_reg_block u_reg_block (
      .clk         (clk),
      .reset       (reset),
      .reg_wr      (reg_wr),
      .reg_rd      (reg_rd),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .busy        (busy),
      .reg_rdata   (reg_rdata),
      .ctrl_enable (ctrl_enable),
      .timing      (timing)
   );

   // --------------------------------------------------------------------------
   // Request queue and bus sequencer
   // --------------------------------------------------------------------------
   rpc_cmd_queue u_cmd_queue (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .pop        (pop),
      .head_valid (head_valid),
      .head       (head),
      .credit     (credit)
   );

   rpc_bus_sequencer u_bus_sequencer (
      .clk         (clk),
      .reset       (reset),
      .ctrl_enable (ctrl_enable),
      .timing      (timing),
      .head_valid  (head_valid),
      .head        (head),
      .rwds_in     (rwds_in),
      .dq_in0      (dq_in0),
      .dq_in1      (dq_in1),
      .pop         (pop),
      .busy        (busy),
      .csn         (csn),
      .ck_en       (ck_en),
      .dq_out_en   (dq_out_en),
      .dq_out0     (dq_out0),
      .dq_out1     (dq_out1),
      .wds_en      (wds_en),
      .wds0        (wds0),
      .wds1        (wds1),
      .rsp_valid   (rsp_valid),
      .rsp_data    (rsp_data),
      .rsp_last    (rsp_last)
   );

endmodule

`default_nettype wire

/* rtl/rpc_pkg.sv */
`default_nettype none

package rpc_pkg;

   // --------------------------------------------------------------------------
   // Sizes and register map
   // --------------------------------------------------------------------------
   localparam int RPC_QUEUE_DEPTH = 4;           // Queue entries and host credits
   localparam int RPC_CA_CYCLES   = 3;           // 48-bit CA word, two bytes per clock

   localparam logic [1:0] RPC_REG_CTRL   = 2'd0;
   localparam logic [1:0] RPC_REG_TIMING = 2'd1;
   localparam logic [1:0] RPC_REG_STATUS = 2'd2;

   typedef logic [15:0] rpc_data_t;
   typedef logic [28:0] rpc_addr_t;              // Word address

   typedef struct packed {
      logic       is_read;
      rpc_addr_t  addr;
      logic [3:0] len;                           // Burst is len + 1 words
      rpc_data_t  wdata;
      logic [1:0] wmask;                         // Bit 1 masks the high byte
   } rpc_req_t;

   typedef struct packed {
      logic [3:0] css;                           // CS low before clock starts
      logic [3:0] csh;                           // CS hold after last data
      logic [3:0] cshi;                          // Minimum CS high time
      logic [3:0] latency;                       // Wait cycles after CA
   } rpc_timing_t;

   // --------------------------------------------------------------------------
   // Command-address word
   // --------------------------------------------------------------------------
   typedef struct packed {
      logic        rw;                           // 1 is read
      logic        as;                           // 0 is memory space
      logic        burst_linear;
      logic [25:0] upper_addr;                   // addr[28:3]
      logic [15:0] reserved;
      logic [2:0]  lower_addr;                   // addr[2:0]
   } rpc_ca_fields_t;

   // Byte 5 goes out first, on dq_out0 of the first CA cycle
   typedef union packed {
      rpc_ca_fields_t  f;
      logic [5:0][7:0] b;
   } rpc_ca_u;

   localparam rpc_timing_t RPC_TIMING_RESET = '{
      css:     4'd1,
      csh:     4'd1,
      cshi:    4'd2,
      latency: 4'd6
   };

endpackage

`default_nettype wire

/* rtl/rpc_reg_block.sv */
`default_nettype none

module rpc_reg_block (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 reg_wr,
   input  wire logic                 reg_rd,
   input  wire logic [1:0]           reg_addr,
   input  wire logic [31:0]          reg_wdata,
   input  wire logic                 busy,
   output logic      [31:0]          reg_rdata,
   output logic                      ctrl_enable,
   output rpc_pkg::rpc_timing_t      timing
);

   import rpc_pkg::*;

   // --------------------------------------------------------------------------
   // Register writes
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         ctrl_enable <= 1'b0;
         timing      <= RPC_TIMING_RESET;
      end else if (reg_wr) begin
         case (reg_addr)
            RPC_REG_CTRL: begin
               ctrl_enable <= reg_wdata[0];            // Bus enable
            end
            RPC_REG_TIMING: begin
               timing <= rpc_timing_t'(reg_wdata[15:0]);
            end
            default: begin
               // Status is read-only, index 3 is unmapped
            end
         endcase
      end
   end

   // --------------------------------------------------------------------------
   // Register reads
   // --------------------------------------------------------------------------
   // Read data is registered and held until the next read
   always_ff @(posedge clk) begin
      if (reset) begin
         reg_rdata <= '0;
      end else if (reg_rd) begin
         case (reg_addr)
            RPC_REG_CTRL: begin
               reg_rdata <= {31'd0, ctrl_enable};
            end
            RPC_REG_TIMING: begin
               reg_rdata <= {16'd0, timing};
            end
            RPC_REG_STATUS: begin
               reg_rdata <= {31'd0, busy};             // Live sequencer state
            end
            default: begin
               reg_rdata <= '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* sim/hyperram_model.sv */
`default_nettype none

module hyperram_model (
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic [3:0]    latency,
   input  wire logic          csn,
   input  wire logic          ck_en,
   input  wire logic [7:0]    dq_out0,
   input  wire logic [7:0]    dq_out1,
   input  wire logic          wds_en,
   input  wire logic          wds0,
   input  wire logic          wds1,
   output logic               rwds_in,
   output logic      [7:0]    dq_in0,
   output logic      [7:0]    dq_in1,
   output logic               ca_valid,
   output logic               ca_rw,
   output rpc_pkg::rpc_addr_t ca_addr,
   output logic               ca_linear
);

   import rpc_pkg::*;

   rpc_data_t   mem [rpc_addr_t];                      // Sparse word storage
   rpc_ca_u     ca_q;
   logic [1:0]  ca_cnt;                                // CA cycles seen so far
   logic [3:0]  lat_cnt;
   logic        rd_mode;
   rpc_addr_t   cur_addr;
   int unsigned beat_cnt = 0;                          // Spaces out idle gaps

   // Unwritten words read back as the low half of their address
   function automatic rpc_data_t stored_word(input rpc_addr_t a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return a[15:0];
   endfunction

   // ------------------------------------------------------------------------
   // Command-address decode and read data
   // ------------------------------------------------------------------------
   always @(posedge clk) begin : bus_cycle
      rpc_ca_u   ca_word;
      rpc_data_t word;
      ca_valid <= 1'b0;
      if (reset || csn) begin
         ca_cnt  <= 2'd0;
         lat_cnt <= 4'd0;
         rd_mode <= 1'b0;
         rwds_in <= 1'b0;
         if (reset) begin
            dq_in0 <= 8'h00;
            dq_in1 <= 8'h00;
         end
      end else if (ck_en && (ca_cnt != 2'd3)) begin
         ca_word = ca_q;
         ca_word.b[5 - 2 * ca_cnt] = dq_out0;          // Rising half first
         ca_word.b[4 - 2 * ca_cnt] = dq_out1;
         ca_q   <= ca_word;
         ca_cnt <= ca_cnt + 2'd1;
         if (ca_cnt == 2'd2) begin
            ca_valid  <= 1'b1;
            ca_rw     <= ca_word.f.rw;
            ca_addr   <= {ca_word.f.upper_addr, ca_word.f.lower_addr};
            ca_linear <= ca_word.f.burst_linear;
            cur_addr  <= {ca_word.f.upper_addr, ca_word.f.lower_addr};
            rd_mode   <= ca_word.f.rw;
            lat_cnt   <= latency;
         end
      end else if (ck_en && rd_mode) begin
         if (lat_cnt != 4'd0) begin
            lat_cnt <= lat_cnt - 4'd1;
            rwds_in <= 1'b0;
         end else if ((beat_cnt % 4) == 3) begin
            beat_cnt <= beat_cnt + 1;                  // Idle beat
            rwds_in  <= 1'b0;
         end else begin
            word = stored_word(cur_addr);
            rwds_in  <= 1'b1;
            dq_in0   <= word[15:8];
            dq_in1   <= word[7:0];
            cur_addr <= cur_addr + 1'b1;
            beat_cnt <= beat_cnt + 1;
         end
      end else begin
         rwds_in <= 1'b0;
      end
   end

   // Masked write, a set strobe keeps the old byte
   always @(posedge clk) begin : write_cycle
      rpc_data_t word;
      if (!reset && !csn && wds_en) begin
         word = stored_word(cur_addr);
         if (!wds0) begin
            word[15:8] = dq_out0;
         end
         if (!wds1) begin
            word[7:0] = dq_out1;
         end
         mem[cur_addr] = word;
      end
   end

endmodule

`default_nettype wire

/* sim/tb_rpc_ctrl.sv */
`default_nettype none

module tb_rpc_ctrl;

   import rpc_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int GATE_REQS    = 4;
   localparam int N_RANDOM     = 40;
   localparam int TOTAL_REQS   = GATE_REQS + N_RANDOM;
   localparam int MAX_WORDS    = TOTAL_REQS * 16 + 1;
   localparam int CSS          = 2;
   localparam int CSH          = 1;
   localparam int CSHI         = 3;
   localparam int LAT          = 4;
   localparam logic [15:0] TIMING_CFG = {4'(CSS), 4'(CSH), 4'(CSHI), 4'(LAT)};

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic        req_valid = 1'b0;
   rpc_req_t    req = '0;
   logic        reg_wr = 1'b0;
   logic        reg_rd = 1'b0;
   logic [1:0]  reg_addr = 2'd0;
   logic [31:0] reg_wdata = 32'd0;
   logic        credit;
   logic        rsp_valid;
   rpc_data_t   rsp_data;
   logic        rsp_last;
   logic [31:0] reg_rdata;
   logic        rwds_in;
   logic [7:0]  dq_in0;
   logic [7:0]  dq_in1;
   logic        csn;
   logic        ck_en;
   logic        dq_out_en;
   logic [7:0]  dq_out0;
   logic [7:0]  dq_out1;
   logic        wds_en;
   logic        wds0;
   logic        wds1;
   logic        ca_valid;
   logic        ca_rw;
   rpc_addr_t   ca_addr;
   logic        ca_linear;

   // ------------------------------------------------------------------------
   // Scoreboard state
   // ------------------------------------------------------------------------
   int          seed = 32'h2105;
   int          credits = RPC_QUEUE_DEPTH;             // Host-side credit count
   int          n_sent = 0;
   int          n_ca = 0;
   int          n_exp = 0;
   int          n_rsp = 0;
   int          high_run = 0;                          // Cycles with csn high
   int          low_run = 0;                           // Cycles with csn low
   rpc_req_t    sent [TOTAL_REQS + 1];                 // Order of issue
   rpc_data_t   exp_data [MAX_WORDS];
   logic        exp_last [MAX_WORDS];
   rpc_data_t   ref_mem [rpc_addr_t];
   rpc_req_t    exp_head;
   rpc_data_t   exp_word;
   logic        exp_word_last;
   logic        dq_drive_exp;
   logic        gate_closed = 1'b0;
   logic        rd_check = 1'b0;
   logic [31:0] rd_expect = 32'd0;
   logic        drained = 1'b0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   rpc_ctrl_top u_rpc_ctrl_top (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .credit    (credit),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .rsp_last  (rsp_last),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .rwds_in   (rwds_in),
      .dq_in0    (dq_in0),
      .dq_in1    (dq_in1),
      .csn       (csn),
      .ck_en     (ck_en),
      .dq_out_en (dq_out_en),
      .dq_out0   (dq_out0),
      .dq_out1   (dq_out1),
      .wds_en    (wds_en),
      .wds0      (wds0),
      .wds1      (wds1)
   );

   hyperram_model u_hyperram_model (
      .clk       (clk),
      .reset     (reset),
      .latency   (4'(LAT)),
      .csn       (csn),
      .ck_en     (ck_en),
      .dq_out0   (dq_out0),
      .dq_out1   (dq_out1),
      .wds_en    (wds_en),
      .wds0      (wds0),
      .wds1      (wds1),
      .rwds_in   (rwds_in),
      .dq_in0    (dq_in0),
      .dq_in1    (dq_in1),
      .ca_valid  (ca_valid),
      .ca_rw     (ca_rw),
      .ca_addr   (ca_addr),
      .ca_linear (ca_linear)
   );

   function automatic rpc_data_t ref_word(input rpc_addr_t a);
      if (ref_mem.exists(a)) begin
         return ref_mem[a];
      end
      return a[15:0];
   endfunction

   // Credits held once this clock edge has taken effect
   function automatic int credits_after_edge();
      return credits - int'(req_valid) + int'(credit);
   endfunction

   function automatic rpc_req_t random_req(input logic [22:0] window);
      rpc_req_t r;
      r.is_read = 1'($random(seed));
      r.addr    = {window, 6'($random(seed))};       // Small window so reads hit writes
      r.len     = 4'($random(seed));
      r.wdata   = 16'($random(seed));
      r.wmask   = 2'($random(seed));
      return r;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      if (reset) begin
         credits <= RPC_QUEUE_DEPTH;
      end else begin
         credits <= credits_after_edge();
      end
      if (ca_valid) begin
         n_ca <= n_ca + 1;
      end
      if (rsp_valid) begin
         n_rsp <= n_rsp + 1;
      end
      if (csn) begin
         high_run <= high_run + 1;
         low_run  <= 0;
      end else begin
         high_run <= 0;
         low_run  <= low_run + 1;
      end
   end

   always_comb begin
      exp_head      = sent[n_ca];
      exp_word      = exp_data[n_rsp];
      exp_word_last = exp_last[n_rsp];
      // CA cycles follow the setup cycles, write data drives once more
      dq_drive_exp  = (!csn && (low_run >= CSS) && (low_run < CSS + RPC_CA_CYCLES)) || wds_en;
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   a_ca_rw: assert property (@(posedge clk) disable iff (reset)
      ca_valid |-> (ca_rw == exp_head.is_read))
      else fail_run($sformatf("Error: time %0t ca_rw expected %b actual %b",
         $time, $sampled(exp_head.is_read), $sampled(ca_rw)));

   a_ca_addr: assert property (@(posedge clk) disable iff (reset)
      ca_valid |-> (ca_addr == exp_head.addr))
      else fail_run($sformatf("Error: time %0t ca_addr expected %h actual %h",
         $time, $sampled(exp_head.addr), $sampled(ca_addr)));

   a_ca_linear: assert property (@(posedge clk) disable iff (reset)
      ca_valid |-> ca_linear)
      else fail_run($sformatf("Error: time %0t ca_linear expected 1 actual %b",
         $time, $sampled(ca_linear)));

   a_cshi: assert property (@(posedge clk) disable iff (reset)
      $fell(csn) |-> (high_run >= CSHI))
      else fail_run($sformatf("Error: time %0t csn high cycles expected %0d actual %0d",
         $time, CSHI, $sampled(high_run)));

   a_css: assert property (@(posedge clk) disable iff (reset)
      (!csn && (low_run < CSS)) |-> !ck_en)
      else fail_run("ck_en went high during the chip-select setup cycles");

   a_dq_out_en: assert property (@(posedge clk) disable iff (reset)
      dq_out_en == dq_drive_exp)
      else fail_run($sformatf("Error: time %0t dq_out_en expected %b actual %b",
         $time, $sampled(dq_drive_exp), $sampled(dq_out_en)));

   a_credit_range: assert property (@(posedge clk) disable iff (reset)
      (credits >= 0) && (credits <= RPC_QUEUE_DEPTH))
      else fail_run($sformatf("Credit counter left its range, now %0d", $sampled(credits)));

   a_gate: assert property (@(posedge clk) disable iff (reset)
      gate_closed |-> (csn && !credit))
      else fail_run("Bus started or credit returned while the controller was disabled");

   a_rsp_extra: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |-> (n_rsp < n_exp))
      else fail_run("Response word arrived with no read word outstanding");

   a_rsp_data: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |-> (rsp_data == exp_word))
      else fail_run($sformatf("Error: time %0t rsp_data expected %h actual %h",
         $time, $sampled(exp_word), $sampled(rsp_data)));

   a_rsp_last: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |-> (rsp_last == exp_word_last))
      else fail_run($sformatf("Error: time %0t rsp_last expected %b actual %b",
         $time, $sampled(exp_word_last), $sampled(rsp_last)));

   a_reg_rdata: assert property (@(posedge clk) disable iff (reset)
      rd_check |-> (reg_rdata == rd_expect))
      else fail_run($sformatf("Error: time %0t reg_rdata expected %h actual %h",
         $time, $sampled(rd_expect), $sampled(reg_rdata)));

   a_drained: assert property (@(posedge clk) disable iff (reset)
      drained |-> (credits == RPC_QUEUE_DEPTH))
      else fail_run($sformatf("Error: time %0t credits expected %0d actual %0d",
         $time, RPC_QUEUE_DEPTH, $sampled(credits)));

   // ------------------------------------------------------------------------
   // Stimulus tasks
   // ------------------------------------------------------------------------
   task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
      @(posedge clk);
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge clk);
      reg_wr <= 1'b0;
   endtask

   task automatic reg_read_check(input logic [1:0] addr, input logic [31:0] value);
      @(posedge clk);
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge clk);
      reg_rd    <= 1'b0;
      rd_check  <= 1'b1;                                // Data is registered
      rd_expect <= value;
      @(posedge clk);
      rd_check <= 1'b0;
   endtask

   // Queue order equals bus order, so expected read data is fixed at issue
   task automatic record_req(input rpc_req_t r);
      rpc_data_t w;
      sent[n_sent] = r;
      n_sent++;
      if (r.is_read) begin
         for (int i = 0; i <= int'(r.len); i++) begin
            exp_data[n_exp] = ref_word(r.addr + rpc_addr_t'(i));
            exp_last[n_exp] = (i == int'(r.len));
            n_exp++;
         end
      end else begin
         w = ref_word(r.addr);
         if (!r.wmask[1]) begin
            w[15:8] = r.wdata[15:8];
         end
         if (!r.wmask[0]) begin
            w[7:0] = r.wdata[7:0];
         end
         ref_mem[r.addr] = w;
      end
   endtask

   task automatic send_req(input rpc_req_t r);
      @(posedge clk);
      while (credits_after_edge() == 0) begin
         req_valid <= 1'b0;
         @(posedge clk);
      end
      req_valid <= 1'b1;
      req       <= r;
      record_req(r);
   endtask

   task automatic end_requests();
      @(posedge clk);
      req_valid <= 1'b0;
   endtask

   task automatic wait_drained();
      do begin
         @(posedge clk);
      end while ((n_rsp != n_exp) || (n_ca != n_sent) || !csn);
      repeat (4) @(posedge clk);
      drained <= 1'b1;
      @(posedge clk);
      drained <= 1'b0;
   endtask

   initial begin : watchdog
      #((RESET_CYCLES + 200 * TOTAL_REQS) * CLK_PERIOD);
      fail_run("Timeout: the run hung before all requests completed");
   end

   initial begin : stimulus
      logic [22:0] window;
      rpc_req_t    r;
      window = 23'($random(seed));
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      // Register port while the bus is still disabled
      reg_write(RPC_REG_TIMING, {16'h0000, TIMING_CFG});
      reg_read_check(RPC_REG_TIMING, {16'h0000, TIMING_CFG});
      reg_read_check(RPC_REG_CTRL, 32'd0);
      reg_write(RPC_REG_STATUS, 32'hffff_ffff);
      reg_read_check(RPC_REG_STATUS, 32'd0);
      reg_read_check(2'd3, 32'd0);

      // Fill the queue with enable low, then release it
      @(posedge clk);
      gate_closed <= 1'b1;
      for (int i = 0; i < GATE_REQS; i++) begin
         r = random_req(window);
         r.is_read   = (i >= 2);
         r.addr[5:0] = 6'(i % 2);                       // Reads revisit both writes
         send_req(r);
      end
      end_requests();
      repeat (30) @(posedge clk);
      gate_closed <= 1'b0;
      reg_write(RPC_REG_CTRL, 32'd1);
      wait_drained();

      // Back-to-back random traffic
      for (int i = 0; i < N_RANDOM; i++) begin
         send_req(random_req(window));
      end
      end_requests();
      wait_drained();

      @(posedge clk);
      if ((n_rsp == n_exp) && (credits == RPC_QUEUE_DEPTH)) begin
         $display("All checks passed");
         $finish;
      end else begin
         fail_run("Responses or credits did not settle at the end of the run");
      end
   end

endmodule

`default_nettype wire
